//--- tb.f
hw/ucodePkg.sv
hw/flowDispatchLut.sv
hw/microcodeRom.sv
hw/microSequencer.sv
hw/uopCore.sv
tests/tbUopCore.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tbUopCore
FILELIST   := tb.f
OBJDIR     := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tests/tbUopCore.sv
`timescale 1ns/1ns
`default_nettype none

module tbUopCore;

	import ucodePkg::*;

	localparam int resetCycles = 4;

	typedef struct packed
	{
		logic isCb;
		logic stray;
		logic [7:0] code;
	} testItem;

	// Expected shape of one flow
	// Key position 0 marks an unused slot
	typedef struct packed
	{
		logic [3:0] len;
		logic jcbEnd;
		logic [3:0] posA;
		uOpKind opA;
		uOperand regA;
		logic anyRegA;
		logic [3:0] posB;
		uOpKind opB;
		uOperand regB;
	} flowExp;

	logic clk;
	logic rstN;
	logic opStrobe;
	logic [7:0] opByte;
	logic ready;
	logic uopValid;
	uopWord uop;

	testItem items[$];
	string itemNames[$];
	flowExp expQ[$];
	string nameQ[$];
	uopWord words[$];
	int testCount = 0;
	int failCount = 0;
	int cycles = 0;
	int cycleLimit = 0;

	uopCore #(.uAddrWidth(10)) dut0
	(
		.clk(clk),
		.rstN(rstN),
		.opStrobe(opStrobe),
		.opByte(opByte),
		.ready(ready),
		.uopValid(uopValid),
		.uop(uop)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////
	// Reference model
	////////////////////

	// Standard 3-bit register field where 6 is (HL)
	function automatic uOperand regOf(input logic [2:0] r);
		case (r)
			3'd0: return rB;
			3'd1: return rC;
			3'd2: return rD;
			3'd3: return rE;
			3'd4: return rH;
			3'd5: return rL;
			3'd7: return rA;
			default: return rNull;
		endcase
	endfunction

	function automatic uOperand pairLo(input logic [1:0] p, input logic stack);
		case (p)
			2'd0: return rC;
			2'd1: return rE;
			2'd2: return rL;
			default: return stack ? rF : rSp;
		endcase
	endfunction

	function automatic uOperand pairHi(input logic [1:0] p, input logic stack);
		case (p)
			2'd0: return rB;
			2'd1: return rD;
			2'd2: return rH;
			default: return stack ? rA : rSp;
		endcase
	endfunction

	// Length and first key word of a flow
	function automatic flowExp firstKey(input flowExp e, input logic [3:0] len,
		input logic [3:0] pos, input uOpKind op, input uOperand rg);
		flowExp n;
		n = e;
		n.len = len;
		n.posA = pos;
		n.opA = op;
		n.regA = rg;
		return n;
	endfunction

	function automatic flowExp secondKey(input flowExp e, input logic [3:0] pos,
		input uOpKind op, input uOperand rg);
		flowExp n;
		n = e;
		n.posB = pos;
		n.opB = op;
		n.regB = rg;
		return n;
	endfunction

	function automatic flowExp refFlow(input logic cb, input logic [7:0] code);
		flowExp e;
		logic [2:0] r;
		logic [2:0] s;
		logic [1:0] p;
		e = '0;
		r = code[5:3];
		s = code[2:0];
		p = code[5:4];
		if (cb)
		begin
			if (code == 8'h7C)
				e = firstKey(e, 4'd2, 4'd1, opBit, rH);
			else if (code == 8'h10)
				e = firstKey(e, 4'd2, 4'd1, opShl, rB);
			else if (code == 8'h38)
				e = firstKey(e, 4'd2, 4'd1, opShr, rB);
			else if (code[7:3] == 5'b00011 && s != 3'd6)
			begin
				e = firstKey(e, 4'd2, 4'd1, opRrot, rNull);
				e.anyRegA = 1'b1;
			end
			else
			begin
				// Unlisted CB byte gives a single no-op word
				e = firstKey(e, 4'd1, 4'd1, opNop, rNull);
				e.anyRegA = 1'b1;
			end
		end
		else if (code == 8'h00)
			e.len = 4'd1;
		else if (code == 8'hCB)
		begin
			e.len = 4'd3;
			e.jcbEnd = 1'b1;
		end
		else if (code[7:6] == 2'b00 && s == 3'b110 && r != 3'd6)
			e = firstKey(e, 4'd3, 4'd3, opSrm, regOf(r));
		else if (code[7:6] == 2'b00 && code[3:0] == 4'h1)
		begin
			e = firstKey(e, 4'd4, 4'd3, opSrm, pairLo(p, 1'b0));
			e = secondKey(e, 4'd4, opSrm, pairHi(p, 1'b0));
		end
		else if (code[7:6] == 2'b00 && s == 3'b100 && r != 3'd6)
			e = firstKey(e, 4'd2, 4'd1, opInc16, regOf(r));
		else if (code[7:6] == 2'b00 && s == 3'b101 && r != 3'd6)
			e = firstKey(e, 4'd2, 4'd1, opDec16, regOf(r));
		else if (code[7:3] == 5'b10000 && s != 3'd6)
			e = firstKey(e, 4'd3, 4'd2, opAddx16u, regOf(s));
		else if (code[7:3] == 5'b10010 && s != 3'd6)
			e = firstKey(e, 4'd3, 4'd2, opSubx16, regOf(s));
		else if (code[7:6] == 2'b11 && code[3:0] == 4'h5)
		begin
			e = firstKey(e, 4'd6, 4'd3, opSmw, pairHi(p, 1'b1));
			e = secondKey(e, 4'd5, opSmw, pairLo(p, 1'b1));
		end
		else if (code[7:6] == 2'b11 && code[3:0] == 4'h1)
		begin
			e = firstKey(e, 4'd6, 4'd3, opSrm, pairLo(p, 1'b1));
			e = secondKey(e, 4'd4, opSrm, pairHi(p, 1'b1));
		end
		else
		begin
			e = firstKey(e, 4'd2, 4'd1, opZ801bop, rNull);
			e.anyRegA = 1'b1;
		end
		return e;
	endfunction

	////////////////////
	// Comparison
	////////////////////

	task automatic checkKey(input string name, input int pos, input uOpKind expOp,
		input uOperand expReg, input logic anyReg, inout logic bad);
		uopWord w;
		if (pos != 0 && pos <= words.size())
		begin
			w = words[pos - 1];
			assert (w.op == expOp) else
			begin
				$display("FAILED %s word %0d op expected %s actual %s",
					name, pos, expOp.name(), w.op.name());
				bad = 1'b1;
			end
			assert (anyReg || w.operand == expReg) else
			begin
				$display("FAILED %s word %0d operand expected %s actual %s",
					name, pos, expReg.name(), w.operand.name());
				bad = 1'b1;
			end
		end
	endtask

	task automatic checkFlow();
		flowExp e;
		string name;
		uopWord w;
		logic bad;
		logic isEnd;
		logic isLast;
		bad = 1'b0;
		assert (expQ.size() != 0) else
		begin
			$display("A flow of %0d words ran with no opcode accepted", words.size());
			failCount++;
		end
		if (expQ.size() != 0)
		begin
			e = expQ.pop_front();
			name = nameQ.pop_front();
			assert (words.size() == int'(e.len)) else
			begin
				$display("FAILED %s length expected %0d actual %0d", name, e.len, words.size());
				bad = 1'b1;
			end
			foreach (words[i])
			begin
				w = words[i];
				isEnd = w.flow inside {fcEof, fcIncEof, fcIncEofFu, fcEofFu};
				isLast = i == words.size() - 1;
				assert (isEnd == (isLast && !e.jcbEnd)) else
				begin
					$display("FAILED %s end flag of word %0d expected %0d actual %0d",
						name, i + 1, isLast && !e.jcbEnd, isEnd);
					bad = 1'b1;
				end
				assert (!isLast || (w.op == opJcb) == e.jcbEnd) else
				begin
					$display("FAILED %s last op expected %s actual %s",
						name, e.jcbEnd ? "opJcb" : "no jump", w.op.name());
					bad = 1'b1;
				end
			end
			checkKey(name, int'(e.posA), e.opA, e.regA, e.anyRegA, bad);
			checkKey(name, int'(e.posB), e.opB, e.regB, 1'b0, bad);
			assert (ready) else
			begin
				$display("ready stayed low after the flow of %s ended", name);
				bad = 1'b1;
			end
			testCount++;
			if (bad)
				failCount++;
			$display("%-16s %s", name, bad ? "failed" : "ok");
		end
	endtask

	// Words are gathered while uopValid is high and checked when it drops
	always @(posedge clk)
	begin
		if (rstN && uopValid)
			words.push_back(uop);
		else if (rstN && words.size() != 0)
		begin
			checkFlow();
			words.delete();
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycleLimit != 0 && cycles > cycleLimit)
		begin
			$display("Timeout, the DUT did not finish within %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	function automatic logic [2:0] randRegCode();
		logic [2:0] pick;
		pick = 3'($urandom % 7);
		return (pick == 3'd6) ? 3'd7 : pick;
	endfunction

	task automatic addTest(input logic isCb, input logic stray, input logic [7:0] code,
		input string name);
		items.push_back('{isCb, stray, code});
		itemNames.push_back(name);
	endtask

	task automatic sendByte(input testItem it, input string name);
		while (!ready)
			@(negedge clk);
		expQ.push_back(refFlow(it.isCb, it.code));
		nameQ.push_back(name);
		opByte = it.code;
		opStrobe = 1'b1;
		@(negedge clk);
		opStrobe = 1'b0;
		// Second strobe lands inside the running flow
		// Its flow is long, so taking it would stretch the length
		if (it.stray)
		begin
			assert (!ready) else
			begin
				$display("Stray strobe for %s found the DUT ready", name);
				failCount++;
			end
			opByte = opcPushBc;
			opStrobe = 1'b1;
			@(negedge clk);
			opStrobe = 1'b0;
		end
	endtask

	initial
	begin
		int first;
		int j;
		int totalLen;
		logic [2:0] r;
		logic [7:0] code;
		logic [7:0] cbBytes [5];
		testItem tmpItem;
		string tmpName;
		rstN = 1'b0;
		opStrobe = 1'b0;
		opByte = 8'h00;
		void'($urandom(34));

		addTest(1'b0, 1'b0, opcNop, "nop");
		first = items.size();
		for (int k = 0; k < 8; k++)
		begin
			code = {2'b00, 3'(k), 3'b110};
			if (k != 6)
				addTest(1'b0, 1'b0, code, $sformatf("ld_r_n %02h", code));
		end
		for (int k = 0; k < 4; k++)
		begin
			code = {2'b00, 2'(k), 4'h1};
			addTest(1'b0, 1'b0, code, $sformatf("ld_rr_nn %02h", code));
			code = {2'b11, 2'(k), 4'h5};
			addTest(1'b0, 1'b0, code, $sformatf("push %02h", code));
			code = {2'b11, 2'(k), 4'h1};
			addTest(1'b0, 1'b0, code, $sformatf("pop %02h", code));
		end
		for (int k = 0; k < 3; k++)
		begin
			code = {2'b00, randRegCode(), 3'b100};
			addTest(1'b0, 1'b0, code, $sformatf("inc %02h", code));
			code = {2'b00, randRegCode(), 3'b101};
			addTest(1'b0, 1'b0, code, $sformatf("dec %02h", code));
			code = {5'b10000, randRegCode()};
			addTest(1'b0, 1'b0, code, $sformatf("add %02h", code));
			code = {5'b10010, randRegCode()};
			addTest(1'b0, 1'b0, code, $sformatf("sub %02h", code));
		end

		// Shuffle the single-byte block
		for (int i = items.size() - 1; i > first; i--)
		begin
			j = first + int'($urandom % (i - first + 1));
			tmpItem = items[i];
			items[i] = items[j];
			items[j] = tmpItem;
			tmpName = itemNames[i];
			itemNames[i] = itemNames[j];
			itemNames[j] = tmpName;
		end

		r = randRegCode();
		cbBytes = '{cbBit7H, cbRlB, cbSrlB, {5'b00011, r}, 8'h00};
		foreach (cbBytes[k])
		begin
			addTest(1'b0, 1'b0, opcMapCb, "map_cb");
			addTest(1'b1, 1'b0, cbBytes[k], $sformatf("cb %02h", cbBytes[k]));
		end
		addTest(1'b0, 1'b1, 8'hA8, "default_stray a8");

		totalLen = 0;
		foreach (items[k])
			totalLen += int'(refFlow(items[k].isCb, items[k].code).len);
		cycleLimit = 4 * totalLen + resetCycles;

		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		testCount++;
		assert (ready && !uopValid) else
		begin
			$display("After reset ready is %0d and uopValid is %0d", ready, uopValid);
			failCount++;
		end
		$display("%-16s %s", "after_reset", (ready && !uopValid) ? "ok" : "failed");

		foreach (items[k])
			sendByte(items[k], itemNames[k]);
		while (expQ.size() != 0 || !ready)
			@(negedge clk);
		// Room for a dropped strobe to show up as an extra flow
		repeat (8) @(negedge clk);

		$display("%0d tests run, %0d failed", testCount, failCount);
		if (failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/uopCore.sv
`timescale 1ns/1ns
`default_nettype none

module uopCore
#(
	parameter int uAddrWidth = 10
)
(
	input wire clk,
	input wire rstN,
	input wire opStrobe,
	input wire [7:0] opByte,
	output logic ready,
	output logic uopValid,
	output ucodePkg::uopWord uop
);

	logic [uAddrWidth-1:0] microPc;
	logic [uAddrWidth-1:0] flowAddr;
	logic cbMode;

	microSequencer #(.uAddrWidth(uAddrWidth)) seq0
	(
		.clk(clk),
		.rstN(rstN),
		.opStrobe(opStrobe),
		.opByte(opByte),
		.flowAddr(flowAddr),
		.cbMode(cbMode),
		.uop(uop),
		.microPc(microPc),
		.uopValid(uopValid),
		.ready(ready)
	);

	// Opcode to entry address, zero latency
	flowDispatchLut #(.uAddrWidth(uAddrWidth)) lut0
	(
		.opByte(opByte),
		.cbMode(cbMode),
		.flowAddr(flowAddr)
	);

	microcodeRom #(.uAddrWidth(uAddrWidth)) rom0
	(
		.addr(microPc),
		.uop(uop)
	);

endmodule

`default_nettype wire

//--- hw/microSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module microSequencer
#(
	parameter int uAddrWidth = 10
)
(
	input wire clk,
	input wire rstN,
	input wire opStrobe,
	input wire [7:0] opByte,
	input wire [uAddrWidth-1:0] flowAddr,
	output logic cbMode,
	input wire ucodePkg::uopWord uop,
	output logic [uAddrWidth-1:0] microPc,
	output logic uopValid,
	output logic ready
);

	import ucodePkg::*;

	logic running;
	logic cbPending;
	logic cbFlow;
	logic accept;
	logic lastWord;
	logic jumpCb;

	////////////////////
	// Decode of the current word
	////////////////////
	assign accept = opStrobe && ready;
	assign lastWord = uop.flow inside {fcEof, fcIncEof, fcIncEofFu, fcEofFu};
	assign jumpCb = uop.op == opJcb;

	assign ready = !running;
	assign uopValid = running;
	// Next accepted byte indexes the CB table
	assign cbMode = cbPending;

	////////////////////
	// Micro-program counter
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			cbPending <= 1'b0;
			cbFlow <= 1'b0;
			microPc <= '0;
		end
		else if (accept)
		begin
			// Entry address comes straight from the dispatch table
			running <= 1'b1;
			cbPending <= 1'b0;
			// Table that the running flow came from
			cbFlow <= cbPending;
			microPc <= flowAddr;
		end
		else if (running)
		begin
			if (lastWord || jumpCb)
			begin
				running <= 1'b0;
			end
			else
			begin
				microPc <= microPc + uAddrWidth'(1);
			end
			// Wait for the byte after the prefix
			if (jumpCb)
			begin
				cbPending <= 1'b1;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Busy strobes are dropped and the running flow goes on
	assert property (@(posedge clk) disable iff (!rstN) opStrobe |-> ready)
	else $warning("opcode %h offered while busy, dropped", opByte);

	// No flow plays while the prefix waits for its byte
	assert property (@(posedge clk) disable iff (!rstN) cbPending |-> !uopValid)
	else $error("micro-op played while a CB prefix is pending");

	// CB flows never chain into a second prefix
	assert property (@(posedge clk) disable iff (!rstN) (uopValid && cbFlow) |-> !jumpCb)
	else $error("jump to CB table inside a CB flow");

endmodule

`default_nettype wire

//--- hw/microcodeRom.sv
`timescale 1ns/1ns
`default_nettype none

module microcodeRom
#(
	parameter int uAddrWidth = 10
)
(
	input wire [uAddrWidth-1:0] addr,
	output ucodePkg::uopWord uop
);

	import ucodePkg::*;

	localparam uopWord nopWord = '{fcOp, opNop, rNull};

	// Pair halves, in flow order bc, de, hl, sp
	// SP has no byte halves in the operand set so both loads name the pair
	localparam uOperand ldLo [numPairs] = '{rC, rE, rL, rSp};
	localparam uOperand ldHi [numPairs] = '{rB, rD, rH, rSp};

	// Stack pairs in flow order bc, de, hl, af
	localparam uOperand stackLo [numPairs] = '{rC, rE, rL, rF};
	localparam uOperand stackHi [numPairs] = '{rB, rD, rH, rA};

	always_comb
	begin
		int a;
		int off;

		a = int'(addr);

		////////////////////
		// Single flows
		////////////////////
		case (a)
			int'(flowDefault):     uop = '{fcUpdFlags, opZ801bop, rA};
			int'(flowDefault) + 1: uop = '{fcIncEof, opNop, rNull};
			int'(flowNop):         uop = '{fcIncEof, opNop, rNull};
			int'(flowMapCb):       uop = '{fcInc, opSma, rPc};
			int'(flowMapCb) + 1:   uop = '{fcOp, opNop, rNull};
			// Hand over to the CB table
			int'(flowMapCb) + 2:   uop = '{fcInc, opJcb, rNull};
			int'(flowCbBit7H):     uop = '{fcUpdFlags, opBit, rH};
			int'(flowCbRl):        uop = '{fcUpdFlags, opShl, rB};
			int'(flowCbSrl):       uop = '{fcUpdFlags, opShr, rB};
			int'(flowCbRr):        uop = '{fcUpdFlags, opRrot, rNull};
			int'(flowCbDefault), int'(flowCbBit7H) + 1, int'(flowCbRl) + 1,
			int'(flowCbSrl) + 1, int'(flowCbRr) + 1:
			begin
				uop = '{fcEof, opNop, rNull};
			end
			default:               uop = nopWord;
		endcase

		////////////////////
		// Register groups
		////////////////////

		// LD r,n
		off = a - int'(flowLdRn_a);
		if (off >= 0 && off < numRegs * lenLdRn)
		begin
			case (off % lenLdRn)
				0:       uop = '{fcInc, opSma, rPc};
				1:       uop = '{fcInc, opNop, rNull};
				default: uop = '{fcEof, opSrm, regOrder[off / lenLdRn]};
			endcase
		end

		// LD rr,nn, low byte arrives first
		off = a - int'(flowLdRrNn_bc);
		if (off >= 0 && off < numPairs * lenLdRrNn)
		begin
			case (off % lenLdRrNn)
				0:       uop = '{fcInc, opSma, rPc};
				1:       uop = '{fcInc, opNop, rNull};
				2:       uop = '{fcOp, opSrm, ldLo[off / lenLdRrNn]};
				default: uop = '{fcIncEof, opSrm, ldHi[off / lenLdRrNn]};
			endcase
		end

		// INC r
		off = a - int'(flowIncR_a);
		if (off >= 0 && off < numRegs * lenIncDec)
		begin
			case (off % lenIncDec)
				0:       uop = '{fcUpdFlags, opInc16, regOrder[off / lenIncDec]};
				default: uop = '{fcIncEof, opNop, rNull};
			endcase
		end

		// DEC r
		off = a - int'(flowDecR_a);
		if (off >= 0 && off < numRegs * lenIncDec)
		begin
			case (off % lenIncDec)
				0:       uop = '{fcUpdFlags, opDec16, regOrder[off / lenIncDec]};
				default: uop = '{fcIncEof, opNop, rNull};
			endcase
		end

		// ADD A,r goes through x16 and back into A
		off = a - int'(flowAddR_a);
		if (off >= 0 && off < numRegs * lenAluR)
		begin
			case (off % lenAluR)
				0:       uop = '{fcOp, opSx16r, rA};
				1:       uop = '{fcUpdFlags, opAddx16u, regOrder[off / lenAluR]};
				default: uop = '{fcIncEof, opSrx16, rA};
			endcase
		end

		// SUB A,r
		off = a - int'(flowSubR_a);
		if (off >= 0 && off < numRegs * lenAluR)
		begin
			case (off % lenAluR)
				0:       uop = '{fcOp, opSx16r, rA};
				1:       uop = '{fcUpdFlags, opSubx16, regOrder[off / lenAluR]};
				default: uop = '{fcIncEof, opSrx16, rA};
			endcase
		end

		// PUSH, high byte goes to the upper stack slot
		off = a - int'(flowPush_bc);
		if (off >= 0 && off < numPairs * lenStack)
		begin
			case (off % lenStack)
				0:       uop = '{fcOp, opDec16, rSp};
				1:       uop = '{fcOp, opSma, rSp};
				2:       uop = '{fcOp, opSmw, stackHi[off / lenStack]};
				3:       uop = '{fcOp, opDec16, rSp};
				4:       uop = '{fcOp, opSmw, stackLo[off / lenStack]};
				default: uop = '{fcIncEof, opSma, rPc};
			endcase
		end

		// POP
		off = a - int'(flowPop_bc);
		if (off >= 0 && off < numPairs * lenStack)
		begin
			case (off % lenStack)
				0:       uop = '{fcOp, opSma, rSp};
				1:       uop = '{fcOp, opInc16, rSp};
				2:       uop = '{fcOp, opSrm, stackLo[off / lenStack]};
				3:       uop = '{fcOp, opSrm, stackHi[off / lenStack]};
				4:       uop = '{fcInc, opInc16, rSp};
				default: uop = '{fcEof, opSma, rPc};
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/flowDispatchLut.sv
`timescale 1ns/1ns
`default_nettype none

module flowDispatchLut
#(
	parameter int uAddrWidth = 10
)
(
	input wire [7:0] opByte,
	input wire cbMode,
	output logic [uAddrWidth-1:0] flowAddr
);

	import ucodePkg::*;

	logic [9:0] mainFlow;
	logic [9:0] cbFlow;

	// Main opcode table
	always_comb
	begin
		case (opByte)
			opcNop:    mainFlow = flowNop;
			opcMapCb:  mainFlow = flowMapCb;
			opcLdAn:   mainFlow = flowLdRn_a;
			opcLdBn:   mainFlow = flowLdRn_b;
			opcLdCn:   mainFlow = flowLdRn_c;
			opcLdDn:   mainFlow = flowLdRn_d;
			opcLdEn:   mainFlow = flowLdRn_e;
			opcLdHn:   mainFlow = flowLdRn_h;
			opcLdLn:   mainFlow = flowLdRn_l;
			opcLdBcNn: mainFlow = flowLdRrNn_bc;
			opcLdDeNn: mainFlow = flowLdRrNn_de;
			opcLdHlNn: mainFlow = flowLdRrNn_hl;
			opcLdSpNn: mainFlow = flowLdRrNn_sp;
			opcIncA:   mainFlow = flowIncR_a;
			opcIncB:   mainFlow = flowIncR_b;
			opcIncC:   mainFlow = flowIncR_c;
			opcIncD:   mainFlow = flowIncR_d;
			opcIncE:   mainFlow = flowIncR_e;
			opcIncH:   mainFlow = flowIncR_h;
			opcIncL:   mainFlow = flowIncR_l;
			opcDecA:   mainFlow = flowDecR_a;
			opcDecB:   mainFlow = flowDecR_b;
			opcDecC:   mainFlow = flowDecR_c;
			opcDecD:   mainFlow = flowDecR_d;
			opcDecE:   mainFlow = flowDecR_e;
			opcDecH:   mainFlow = flowDecR_h;
			opcDecL:   mainFlow = flowDecR_l;
			opcAddA:   mainFlow = flowAddR_a;
			opcAddB:   mainFlow = flowAddR_b;
			opcAddC:   mainFlow = flowAddR_c;
			opcAddD:   mainFlow = flowAddR_d;
			opcAddE:   mainFlow = flowAddR_e;
			opcAddH:   mainFlow = flowAddR_h;
			opcAddL:   mainFlow = flowAddR_l;
			opcSubA:   mainFlow = flowSubR_a;
			opcSubB:   mainFlow = flowSubR_b;
			opcSubC:   mainFlow = flowSubR_c;
			opcSubD:   mainFlow = flowSubR_d;
			opcSubE:   mainFlow = flowSubR_e;
			opcSubH:   mainFlow = flowSubR_h;
			opcSubL:   mainFlow = flowSubR_l;
			opcPushBc: mainFlow = flowPush_bc;
			opcPushDe: mainFlow = flowPush_de;
			opcPushHl: mainFlow = flowPush_hl;
			opcPushAf: mainFlow = flowPush_af;
			opcPopBc:  mainFlow = flowPop_bc;
			opcPopDe:  mainFlow = flowPop_de;
			opcPopHl:  mainFlow = flowPop_hl;
			opcPopAf:  mainFlow = flowPop_af;
			// Anything else runs as a generic one-byte ALU op
			default:   mainFlow = flowDefault;
		endcase
	end

	// CB table, only consulted right after the prefix
	always_comb
	begin
		case (opByte)
			cbBit7H: cbFlow = flowCbBit7H;
			cbRlB:   cbFlow = flowCbRl;
			cbSrlB:  cbFlow = flowCbSrl;
			cbRrA, cbRrB, cbRrC, cbRrD, cbRrE, cbRrH, cbRrL:
			begin
				cbFlow = flowCbRr;
			end
			default: cbFlow = flowCbDefault;
		endcase
	end

	assign flowAddr = uAddrWidth'(cbMode ? cbFlow : mainFlow);

endmodule

`default_nettype wire

//--- hw/ucodePkg.sv
`default_nettype none

package ucodePkg;

	// Flow control field, tells the sequencer how to advance
	typedef enum logic [2:0]
	{
		fcOp       = 3'd0,
		fcInc      = 3'd1,
		fcEof      = 3'd2,
		fcIncEof   = 3'd3,
		fcUpdFlags = 3'd4,
		fcIncEofFu = 3'd5,
		fcEofFu    = 3'd6
	} uFlowCtl;

	typedef enum logic [5:0]
	{
		opNop, opSma, opSmw, opSrm, opSx16r, opSrx16, opInc16, opDec16,
		opAddx16u, opSubx16, opJcb, opBit, opShl, opShr, opRrot, opZ801bop
	} uOpKind;

	typedef enum logic [5:0]
	{
		rA, rB, rC, rD, rE, rH, rL, rF,
		rBc, rDe, rHl, rSp, rPc, rX16, rNull
	} uOperand;

	typedef struct packed
	{
		uFlowCtl flow;
		uOpKind  op;
		uOperand operand;
	} uopWord;

	////////////////////
	// Opcodes
	////////////////////
	localparam logic [7:0]
		opcNop = 8'h00, opcMapCb = 8'hCB,
		opcLdAn = 8'h3E, opcLdBn = 8'h06, opcLdCn = 8'h0E, opcLdDn = 8'h16,
		opcLdEn = 8'h1E, opcLdHn = 8'h26, opcLdLn = 8'h2E,
		opcLdBcNn = 8'h01, opcLdDeNn = 8'h11, opcLdHlNn = 8'h21, opcLdSpNn = 8'h31,
		opcIncA = 8'h3C, opcIncB = 8'h04, opcIncC = 8'h0C, opcIncD = 8'h14,
		opcIncE = 8'h1C, opcIncH = 8'h24, opcIncL = 8'h2C,
		opcDecA = 8'h3D, opcDecB = 8'h05, opcDecC = 8'h0D, opcDecD = 8'h15,
		opcDecE = 8'h1D, opcDecH = 8'h25, opcDecL = 8'h2D,
		opcAddA = 8'h87, opcAddB = 8'h80, opcAddC = 8'h81, opcAddD = 8'h82,
		opcAddE = 8'h83, opcAddH = 8'h84, opcAddL = 8'h85,
		opcSubA = 8'h97, opcSubB = 8'h90, opcSubC = 8'h91, opcSubD = 8'h92,
		opcSubE = 8'h93, opcSubH = 8'h94, opcSubL = 8'h95,
		opcPushBc = 8'hC5, opcPushDe = 8'hD5, opcPushHl = 8'hE5, opcPushAf = 8'hF5,
		opcPopBc = 8'hC1, opcPopDe = 8'hD1, opcPopHl = 8'hE1, opcPopAf = 8'hF1;

	// Second byte after the CB prefix
	localparam logic [7:0]
		cbBit7H = 8'h7C, cbRlB = 8'h10, cbSrlB = 8'h38,
		cbRrA = 8'h1F, cbRrB = 8'h18, cbRrC = 8'h19, cbRrD = 8'h1A,
		cbRrE = 8'h1B, cbRrH = 8'h1C, cbRrL = 8'h1D;

	////////////////////
	// Flow entry points
	////////////////////
	localparam logic [9:0]
		flowCbDefault = 10'd0, flowDefault = 10'd1, flowNop = 10'd3, flowMapCb = 10'd4,
		flowCbBit7H = 10'd7, flowCbRl = 10'd9, flowCbSrl = 10'd11, flowCbRr = 10'd13,
		flowLdRn_a = 10'd16, flowLdRn_b = 10'd19, flowLdRn_c = 10'd22, flowLdRn_d = 10'd25,
		flowLdRn_e = 10'd28, flowLdRn_h = 10'd31, flowLdRn_l = 10'd34,
		flowLdRrNn_bc = 10'd40, flowLdRrNn_de = 10'd44,
		flowLdRrNn_hl = 10'd48, flowLdRrNn_sp = 10'd52,
		flowIncR_a = 10'd56, flowIncR_b = 10'd58, flowIncR_c = 10'd60, flowIncR_d = 10'd62,
		flowIncR_e = 10'd64, flowIncR_h = 10'd66, flowIncR_l = 10'd68,
		flowDecR_a = 10'd70, flowDecR_b = 10'd72, flowDecR_c = 10'd74, flowDecR_d = 10'd76,
		flowDecR_e = 10'd78, flowDecR_h = 10'd80, flowDecR_l = 10'd82,
		flowAddR_a = 10'd84, flowAddR_b = 10'd87, flowAddR_c = 10'd90, flowAddR_d = 10'd93,
		flowAddR_e = 10'd96, flowAddR_h = 10'd99, flowAddR_l = 10'd102,
		flowSubR_a = 10'd105, flowSubR_b = 10'd108, flowSubR_c = 10'd111,
		flowSubR_d = 10'd114, flowSubR_e = 10'd117, flowSubR_h = 10'd120,
		flowSubR_l = 10'd123,
		flowPush_bc = 10'd128, flowPush_de = 10'd134, flowPush_hl = 10'd140,
		flowPush_af = 10'd146,
		flowPop_bc = 10'd152, flowPop_de = 10'd158, flowPop_hl = 10'd164,
		flowPop_af = 10'd170;

	// Group flows sit back to back, one stride per flow length
	localparam int lenLdRn = 3;
	localparam int lenLdRrNn = 4;
	localparam int lenIncDec = 2;
	localparam int lenAluR = 3;
	localparam int lenStack = 6;
	localparam int numRegs = 7;
	localparam int numPairs = 4;

	// Register order of every per-register group above
	localparam uOperand regOrder [numRegs] = '{rA, rB, rC, rD, rE, rH, rL};

endpackage

`default_nettype wire
